/* msdap_top.f */
common/msdap_pkg.sv
verilog/word_deserializer.sv
verilog/msdap_controller.sv
filter/tap_sequencer.sv
filter/shift_accumulator.sv
filter/filter_channel.sv
verilog/result_serializer.sv
verilog/msdap_top.sv
verif/msdap_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the MSDAP testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module msdap_tb \
	-f msdap_top.f -o msdap_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/msdap_sim)"
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

/* verif/msdap_cases.txt */
# tag left right in hex: R run lengths, C coefficients, S samples
# E expected 40-bit left and right results, N no output for the sample before
R 0004 0002
R 0004 0006
R 0004 0003
R 0004 0005
C 0000 0100
C 0103 0006
C 000a 0001
C 001f 0003
C 0001 0108
C 0002 0010
C 0114 0016
C 0007 011d
C 0100 0002
C 0004 0109
C 000c 001f
C 0119 0000
C 0102 0104
C 0005 000b
C 000f 0012
C 001e 011b
S 0002 ffff
E ffffffa000 ffffff9000
S 0000 0000
E 0000004000 ffffffe000
S 0000 0000
E ffffff4000 ffffffc000
S 0000 0000
E ffffffe000 ffffffe000
S 0000 0000
E 0000008000 0000008000
S 0000 0000
E 0000010000 0000000000
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0004 0003
E ffffff6000 0000015000
S fffd 0005
E 0000011000 0000021000
S 0007 fffe
E fffffd5000 0000008000
S fffb 0001
E 000002b000 000001d000
S 0001 fffc
E fffffdc000 fffffd0000
S 0000 0000
E 000003d000 fffffd0000
S 0000 0000
E 0000003000 0000003000
S 0000 0000
E 000002b000 ffffff5000
S 0000 0000
E fffffd6000 0000010000
S 0000 0000
E 0000016000 fffffeb000
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0000 0000
N
S 0002 0000
E 0000004000 000000a000
S ffff 0002
E 0000005000 000000a000
S 0000 0000
E fffffe2000 0000006000

/* verif/msdap_tb.sv */
`timescale 1ns/1ps

module msdap_tb
	import msdap_pkg::*;
();

	localparam int NUM_RJ = 4;
	localparam int NUM_COEFF = 16;
	localparam int DATA_DEPTH = 32;
	localparam int ZERO_RUN = 6;
	localparam int PERIOD = 100;

	logic Sclk;
	logic rst_n;
	logic frame;
	logic input_l;
	logic input_r;
	logic in_ready;
	logic out_ready;
	logic output_l;
	logic output_r;

	byte case_tag [$];
	logic [63:0] case_l [$];
	logic [63:0] case_r [$];
	logic [ACC_W-1:0] got_l [$];
	logic [ACC_W-1:0] got_r [$];
	int got_len [$];
	int num_words;
	int errors;
	int checks;

	// monitor state
	logic [ACC_W-1:0] shift_l;
	logic [ACC_W-1:0] shift_r;
	int nbits;
	int ready_cycles;
	logic ready_seen;
	logic in_ready_dropped;

	msdap_top #(
		.NUM_RJ(NUM_RJ),
		.NUM_COEFF(NUM_COEFF),
		.DATA_DEPTH(DATA_DEPTH),
		.ZERO_RUN(ZERO_RUN)
	) UUT (
		.Sclk(Sclk), .rst_n(rst_n), .frame(frame),
		.input_l(input_l), .input_r(input_r),
		.in_ready(in_ready), .out_ready(out_ready),
		.output_l(output_l), .output_r(output_r)
	);

	initial
	begin
		Sclk = 1'b0;
		forever #(PERIOD / 2) Sclk = ~Sclk;
	end

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// frame goes with the MSB and both lanes shift together
	task automatic send_pair(input logic [WORD_W-1:0] l, input logic [WORD_W-1:0] r);
		int i;
		for (i = 0; i < WORD_W; i++)
		begin
			@(posedge Sclk);
			frame <= (i == 0);
			input_l <= l[WORD_W-1-i];
			input_r <= r[WORD_W-1-i];
		end
		@(posedge Sclk);
		frame <= 1'b0;
		input_l <= 1'b0;
		input_r <= 1'b0;
	endtask

	task automatic read_cases();
		int fd;
		int code;
		int words;
		string line;
		logic [63:0] a;
		logic [63:0] b;
		words = 0;
		fd = $fopen("verif/msdap_cases.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open the cases file verif/msdap_cases.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1)
				begin
					a = '0;
					b = '0;
					if (line[0] == "R" || line[0] == "C" || line[0] == "S" || line[0] == "E")
					begin
						code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
						if (code != 2)
						begin
							errors++;
							$display("malformed line in the cases file: %s", line);
						end
						if (line[0] != "E")
							words++;
					end
					if (line[0] == "R" || line[0] == "C" || line[0] == "S" ||
						line[0] == "E" || line[0] == "N")
					begin
						case_tag.push_back(line[0]);
						case_l.push_back(a);
						case_r.push_back(b);
					end
				end
			end
			$fclose(fd);
		end
		num_words = words;
	endtask

	// output monitor on the falling edge
	always @(negedge Sclk)
	begin
		if (!rst_n)
		begin
			nbits <= 0;
			ready_cycles <= 0;
			ready_seen <= 1'b0;
			in_ready_dropped <= 1'b0;
		end
		else
		begin
			if (in_ready)
				ready_seen <= 1'b1;
			else if (ready_seen)
				in_ready_dropped <= 1'b1;
			if (out_ready)
			begin
				shift_l <= {shift_l[ACC_W-2:0], output_l};
				shift_r <= {shift_r[ACC_W-2:0], output_r};
				nbits <= nbits + 1;
				ready_cycles <= ready_cycles + 1;
			end
			else if (nbits != 0)
			begin
				got_l.push_back(shift_l);
				got_r.push_back(shift_r);
				got_len.push_back(nbits);
				nbits <= 0;
			end
		end
	end

	initial
	begin
		wait (rst_n === 1'b1);
		repeat (num_words * 4 * NUM_COEFF + 1000) @(posedge Sclk);
		$display("watchdog expired before all cases were run");
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		int idx;
		int next_result;
		int sample_no;
		int snapshot;
		frame = 1'b0;
		input_l = 1'b0;
		input_r = 1'b0;
		rst_n = 1'b0;
		errors = 0;
		checks = 0;
		num_words = 0;
		next_result = 0;
		sample_no = 0;
		read_cases();

		repeat (16) @(posedge Sclk);
		check_value("in_ready in reset", 64'(in_ready), 64'd0);
		check_value("out_ready in reset", 64'(out_ready), 64'd0);
		check_value("output_l in reset", 64'(output_l), 64'd0);
		check_value("output_r in reset", 64'(output_r), 64'd0);
		rst_n <= 1'b1;
		repeat (3) @(posedge Sclk);
		check_value("in_ready after reset", 64'(in_ready), 64'd1);

		for (idx = 0; idx < case_tag.size(); idx++)
		begin
			if (case_tag[idx] == "R" || case_tag[idx] == "C")
			begin
				send_pair(case_l[idx][WORD_W-1:0], case_r[idx][WORD_W-1:0]);
				// load frames start 4 x NUM_COEFF cycles apart
				repeat (4 * NUM_COEFF - WORD_W - 1) @(posedge Sclk);
			end
			else if (case_tag[idx] == "S")
			begin
				send_pair(case_l[idx][WORD_W-1:0], case_r[idx][WORD_W-1:0]);
				sample_no++;
			end
			else if (case_tag[idx] == "E")
			begin
				// result is queued once out_ready has dropped
				while (got_l.size() <= next_result)
					@(posedge Sclk);
				check_value($sformatf("bit count of sample %0d", sample_no - 1),
					64'(got_len[next_result]), 64'(ACC_W));
				check_value($sformatf("left result of sample %0d", sample_no - 1),
					64'(got_l[next_result]), case_l[idx]);
				check_value($sformatf("right result of sample %0d", sample_no - 1),
					64'(got_r[next_result]), case_r[idx]);
				next_result++;
			end
			else
			begin
				snapshot = ready_cycles;
				repeat (4 * NUM_COEFF) @(posedge Sclk);
				check_value($sformatf("out_ready cycles while asleep at sample %0d",
					sample_no - 1), 64'(ready_cycles), 64'(snapshot));
			end
		end

		repeat (4) @(posedge Sclk);
		check_value("number of results", 64'(got_l.size()), 64'(next_result));
		check_value("in_ready dropped", 64'(in_ready_dropped), 64'd0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog/msdap_top.sv */
`timescale 1ns/1ps

module msdap_top
	import msdap_pkg::*;
#(
	parameter int NUM_RJ = 16,
	parameter int NUM_COEFF = 512,
	parameter int DATA_DEPTH = 256,
	parameter int ZERO_RUN = 800
)
(
	input  logic Sclk,
	input  logic rst_n,
	input  logic frame,
	input  logic input_l,
	input  logic input_r,
	output logic in_ready,
	output logic out_ready,
	output logic output_l,
	output logic output_r
);

	word_pair_t words;
	logic word_valid;
	load_cmd_t load_cmd;
	logic start;
	logic [ACC_W-1:0] result_l;
	logic [ACC_W-1:0] result_r;
	logic done_l;
	logic done_r;

	word_deserializer u_deser (
		.Sclk(Sclk), .rst_n(rst_n), .frame(frame),
		.input_l(input_l), .input_r(input_r),
		.words(words), .word_valid(word_valid)
	);

	msdap_controller #(.NUM_RJ(NUM_RJ), .NUM_COEFF(NUM_COEFF), .ZERO_RUN(ZERO_RUN)) u_ctrl (
		.Sclk(Sclk), .rst_n(rst_n), .words(words), .word_valid(word_valid),
		.load_cmd(load_cmd), .start(start), .in_ready(in_ready)
	);

	filter_channel #(.NUM_RJ(NUM_RJ), .NUM_COEFF(NUM_COEFF), .DATA_DEPTH(DATA_DEPTH)) u_chan_l (
		.Sclk(Sclk), .rst_n(rst_n), .word(words.left), .load_cmd(load_cmd),
		.start(start), .result(result_l), .done(done_l)
	);

	filter_channel #(.NUM_RJ(NUM_RJ), .NUM_COEFF(NUM_COEFF), .DATA_DEPTH(DATA_DEPTH)) u_chan_r (
		.Sclk(Sclk), .rst_n(rst_n), .word(words.right), .load_cmd(load_cmd),
		.start(start), .result(result_r), .done(done_r)
	);

	result_serializer u_ser (
		.Sclk(Sclk), .rst_n(rst_n),
		.result_l(result_l), .result_r(result_r), .done_l(done_l), .done_r(done_r),
		.out_ready(out_ready), .output_l(output_l), .output_r(output_r)
	);

endmodule

/* verilog/result_serializer.sv */
`timescale 1ns/1ps

module result_serializer
	import msdap_pkg::*;
(
	input  logic Sclk,
	input  logic rst_n,
	input  logic [ACC_W-1:0] result_l,
	input  logic [ACC_W-1:0] result_r,
	input  logic done_l,
	input  logic done_r,
	output logic out_ready,
	output logic output_l,
	output logic output_r
);

	localparam int CNT_W = $clog2(ACC_W);

	logic [ACC_W-1:0] sh_l;
	logic [ACC_W-1:0] sh_r;
	logic [CNT_W-1:0] bits_left;

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sh_l <= '0;
			sh_r <= '0;
			bits_left <= '0;
			out_ready <= 1'b0;
			output_l <= 1'b0;
			output_r <= 1'b0;
		end
		else if (done_l || done_r)
		begin
			// MSB goes out right away
			out_ready <= 1'b1;
			output_l <= result_l[ACC_W-1];
			output_r <= result_r[ACC_W-1];
			sh_l <= {result_l[ACC_W-2:0], 1'b0};
			sh_r <= {result_r[ACC_W-2:0], 1'b0};
			bits_left <= CNT_W'(ACC_W - 1);
		end
		else if (bits_left != '0)
		begin
			output_l <= sh_l[ACC_W-1];
			output_r <= sh_r[ACC_W-1];
			sh_l <= {sh_l[ACC_W-2:0], 1'b0};
			sh_r <= {sh_r[ACC_W-2:0], 1'b0};
			bits_left <= bits_left - 1'b1;
		end
		else
		begin
			out_ready <= 1'b0;
			output_l <= 1'b0;
			output_r <= 1'b0;
		end
	end

	// both channels run identical group lengths
	a_done_sync: assert property (@(posedge Sclk) disable iff (!rst_n)
		done_l == done_r)
		else $error("left and right done pulses differ");

endmodule

/* filter/filter_channel.sv */
`timescale 1ns/1ps

module filter_channel
	import msdap_pkg::*;
#(
	parameter int NUM_RJ = 16,
	parameter int NUM_COEFF = 512,
	parameter int DATA_DEPTH = 256
)
(
	input  logic Sclk,
	input  logic rst_n,
	input  msdap_word_u word,
	input  load_cmd_t load_cmd,
	input  logic start,
	output logic [ACC_W-1:0] result,
	output logic done
);

	localparam int RW = $clog2(NUM_RJ);
	localparam int CW = $clog2(NUM_COEFF);
	localparam int HW = $clog2(DATA_DEPTH);
	localparam int FW = $clog2(DATA_DEPTH + 1);

	msdap_word_u rj_mem [NUM_RJ];
	msdap_word_u coeff_mem [NUM_COEFF];
	msdap_word_u hist_mem [DATA_DEPTH];

	logic [RW-1:0] rj_wp;
	logic [RW-1:0] rj_addr;
	logic [CW-1:0] coeff_wp;
	logic [CW-1:0] coeff_addr;
	logic [HW-1:0] hist_wp;
	logic [HW-1:0] hist_addr;
	logic [HW-1:0] newest;
	logic [FW-1:0] fill;
	logic [31:0] rj_sum;
	acc_op_t op;

	always_ff @(posedge Sclk)
	begin
		if (load_cmd.rj_we)
			rj_mem[rj_wp] <= word;
		if (load_cmd.coeff_we)
			coeff_mem[coeff_wp] <= word;
		if (load_cmd.sample_we)
			hist_mem[hist_wp] <= word;
	end

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rj_wp <= '0;
			coeff_wp <= '0;
			hist_wp <= '0;
			fill <= '0;
			rj_sum <= '0;
		end
		else
		begin
			if (load_cmd.rj_we)
			begin
				rj_wp <= rj_wp + 1'b1;
				rj_sum <= rj_sum + 32'(word.raw);
			end
			if (load_cmd.coeff_we)
				coeff_wp <= coeff_wp + 1'b1;
			if (load_cmd.sample_we)
			begin
				if (hist_wp == HW'(DATA_DEPTH - 1))
					hist_wp <= '0;
				else
					hist_wp <= hist_wp + 1'b1;
				if (fill != FW'(DATA_DEPTH))
					fill <= fill + 1'b1;
			end
		end
	end

	assign newest = (hist_wp == '0) ? HW'(DATA_DEPTH - 1) : hist_wp - 1'b1;

	tap_sequencer #(.NUM_RJ(NUM_RJ), .NUM_COEFF(NUM_COEFF), .DATA_DEPTH(DATA_DEPTH)) u_seq (
		.Sclk(Sclk), .rst_n(rst_n), .start(start),
		.rj(rj_mem[rj_addr].raw), .coeff(coeff_mem[coeff_addr].coeff),
		.newest(newest), .fill(fill),
		.rj_addr(rj_addr), .coeff_addr(coeff_addr), .hist_addr(hist_addr),
		.op(op), .done(done)
	);

	shift_accumulator u_acc (
		.Sclk(Sclk), .rst_n(rst_n), .op(op),
		.sample(hist_mem[hist_addr]), .acc(result)
	);

	// groups must cover every coefficient exactly once
	a_rj_sum: assert property (@(posedge Sclk) disable iff (!rst_n)
		(load_cmd.coeff_we && coeff_wp == CW'(NUM_COEFF - 1)) |-> rj_sum == NUM_COEFF)
		else $error("run lengths do not sum to NUM_COEFF");

endmodule

/* filter/shift_accumulator.sv */
`timescale 1ns/1ps

module shift_accumulator
	import msdap_pkg::*;
(
	input  logic Sclk,
	input  logic rst_n,
	input  acc_op_t op,
	input  msdap_word_u sample,
	output logic [ACC_W-1:0] acc
);

	logic [ACC_W-1:0] aligned;

	// sign extend, sample LSB lands on SAMPLE_LSB
	assign aligned = {{(ACC_W - WORD_W - SAMPLE_LSB){sample.raw[WORD_W-1]}},
		sample.raw, {SAMPLE_LSB{1'b0}}};

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
			acc <= '0;
		else if (op.clear)
			acc <= '0;
		else if (op.add)
			acc <= op.neg ? acc - aligned : acc + aligned;
		else if (op.shift)
			acc <= {acc[ACC_W-1], acc[ACC_W-1:1]};
	end

endmodule

/* filter/tap_sequencer.sv */
`timescale 1ns/1ps

module tap_sequencer
	import msdap_pkg::*;
#(
	parameter int NUM_RJ = 16,
	parameter int NUM_COEFF = 512,
	parameter int DATA_DEPTH = 256
)
(
	input  logic Sclk,
	input  logic rst_n,
	input  logic start,
	input  logic [WORD_W-1:0] rj,
	input  coeff_fields_t coeff,
	input  logic [$clog2(DATA_DEPTH)-1:0] newest,
	input  logic [$clog2(DATA_DEPTH+1)-1:0] fill,
	output logic [$clog2(NUM_RJ)-1:0] rj_addr,
	output logic [$clog2(NUM_COEFF)-1:0] coeff_addr,
	output logic [$clog2(DATA_DEPTH)-1:0] hist_addr,
	output acc_op_t op,
	output logic done
);

	localparam int RW = $clog2(NUM_RJ);
	localparam int HW = $clog2(DATA_DEPTH);

	logic running;
	logic last_q;
	logic [WORD_W-1:0] k_cnt;
	logic [HW-1:0] tap_addr;

	// newest - k, modulo the history depth
	always_comb
	begin
		int unsigned wrapped;
		wrapped = int'(newest) + DATA_DEPTH - int'(coeff.idx);
		if (wrapped >= DATA_DEPTH)
			wrapped = wrapped - DATA_DEPTH;
		tap_addr = HW'(wrapped);
	end

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			last_q <= 1'b0;
			k_cnt <= '0;
			rj_addr <= '0;
			coeff_addr <= '0;
			hist_addr <= '0;
			op <= '0;
			done <= 1'b0;
		end
		else
		begin
			op <= '0;
			last_q <= 1'b0;
			// done trails the last shift so the result is settled
			done <= last_q;
			if (start)
			begin
				running <= 1'b1;
				op.clear <= 1'b1;
				k_cnt <= '0;
				rj_addr <= '0;
				coeff_addr <= '0;
			end
			else if (running)
			begin
				if (k_cnt == rj)
				begin
					op.shift <= 1'b1;
					k_cnt <= '0;
					if (rj_addr == RW'(NUM_RJ - 1))
					begin
						running <= 1'b0;
						last_q <= 1'b1;
					end
					else
						rj_addr <= rj_addr + 1'b1;
				end
				else
				begin
					// taps older than the first sample read as zero
					op.add <= int'(coeff.idx) < int'(fill);
					op.neg <= coeff.neg;
					hist_addr <= tap_addr;
					coeff_addr <= coeff_addr + 1'b1;
					k_cnt <= k_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/msdap_controller.sv */
`timescale 1ns/1ps

module msdap_controller
	import msdap_pkg::*;
#(
	parameter int NUM_RJ = 16,
	parameter int NUM_COEFF = 512,
	parameter int ZERO_RUN = 800
)
(
	input  logic Sclk,
	input  logic rst_n,
	input  word_pair_t words,
	input  logic word_valid,
	output load_cmd_t load_cmd,
	output logic start,
	output logic in_ready
);

	localparam int LW = $clog2(NUM_COEFF);
	localparam int ZW = $clog2(ZERO_RUN + 1);
	// cycles from word_valid until the channels raise done
	localparam int BUSY_CYC = NUM_COEFF + NUM_RJ + 2;
	localparam int KW = $clog2(BUSY_CYC + 1);

	typedef enum logic [1:0] {LOAD_RJ, LOAD_COEFF, RUN, SLEEP} phase_t;

	phase_t phase;
	logic [LW-1:0] load_cnt;
	logic [ZW-1:0] zl_cnt;
	logic [ZW-1:0] zr_cnt;
	logic [ZW-1:0] zl_next;
	logic [ZW-1:0] zr_next;
	logic sleep_now;
	logic [KW-1:0] busy_cnt;

	// zero runs including the current pair, saturating at ZERO_RUN
	always_comb
	begin
		if (words.left.raw != '0)
			zl_next = '0;
		else if (zl_cnt == ZW'(ZERO_RUN))
			zl_next = zl_cnt;
		else
			zl_next = zl_cnt + 1'b1;
		if (words.right.raw != '0)
			zr_next = '0;
		else if (zr_cnt == ZW'(ZERO_RUN))
			zr_next = zr_cnt;
		else
			zr_next = zr_cnt + 1'b1;
		sleep_now = (zl_next == ZW'(ZERO_RUN)) && (zr_next == ZW'(ZERO_RUN));
	end

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= LOAD_RJ;
			load_cnt <= '0;
			zl_cnt <= '0;
			zr_cnt <= '0;
			load_cmd <= '0;
			start <= 1'b0;
			in_ready <= 1'b0;
			busy_cnt <= '0;
		end
		else
		begin
			in_ready <= 1'b1;
			load_cmd <= '0;
			start <= 1'b0;
			if (busy_cnt != '0)
				busy_cnt <= busy_cnt - 1'b1;
			if (word_valid)
			begin
				case (phase)
					LOAD_RJ:
					begin
						load_cmd.rj_we <= 1'b1;
						if (load_cnt == LW'(NUM_RJ - 1))
						begin
							phase <= LOAD_COEFF;
							load_cnt <= '0;
						end
						else
							load_cnt <= load_cnt + 1'b1;
					end
					LOAD_COEFF:
					begin
						load_cmd.coeff_we <= 1'b1;
						if (load_cnt == LW'(NUM_COEFF - 1))
						begin
							phase <= RUN;
							load_cnt <= '0;
						end
						else
							load_cnt <= load_cnt + 1'b1;
					end
					default:
					begin
						// sleeping pairs still go into the history
						load_cmd.sample_we <= 1'b1;
						zl_cnt <= zl_next;
						zr_cnt <= zr_next;
						if (sleep_now)
							phase <= SLEEP;
						else
						begin
							phase <= RUN;
							start <= 1'b1;
							busy_cnt <= KW'(BUSY_CYC);
						end
					end
				endcase
			end
		end
	end

	a_no_overrun: assert property (@(posedge Sclk) disable iff (!rst_n)
		word_valid |-> busy_cnt == '0)
		else $error("input word arrived during a computation");

endmodule

/* verilog/word_deserializer.sv */
`timescale 1ns/1ps

module word_deserializer
	import msdap_pkg::*;
(
	input  logic Sclk,
	input  logic rst_n,
	input  logic frame,
	input  logic input_l,
	input  logic input_r,
	output word_pair_t words,
	output logic word_valid
);

	localparam int BW = $clog2(WORD_W);

	logic [WORD_W-1:0] sh_l;
	logic [WORD_W-1:0] sh_r;
	logic [BW-1:0] bit_cnt;
	logic busy;

	always_ff @(posedge Sclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sh_l <= '0;
			sh_r <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
			words <= '0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= 1'b0;
			// frame always restarts the word, even mid-word
			if (frame)
			begin
				sh_l <= {sh_l[WORD_W-2:0], input_l};
				sh_r <= {sh_r[WORD_W-2:0], input_r};
				bit_cnt <= BW'(1);
				busy <= 1'b1;
			end
			else if (busy)
			begin
				sh_l <= {sh_l[WORD_W-2:0], input_l};
				sh_r <= {sh_r[WORD_W-2:0], input_r};
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == BW'(WORD_W - 1))
				begin
					busy <= 1'b0;
					word_valid <= 1'b1;
					words.left.raw <= {sh_l[WORD_W-2:0], input_l};
					words.right.raw <= {sh_r[WORD_W-2:0], input_r};
				end
			end
		end
	end

endmodule

/* common/msdap_pkg.sv */
package msdap_pkg;

	localparam int WORD_W = 16;
	localparam int ACC_W = 40;
	localparam int SAMPLE_LSB = 16;
	localparam int IDX_W = 8;

	// coefficient word layout
	typedef struct packed
	{
		logic [6:0] pad;
		logic neg;
		logic [IDX_W-1:0] idx;
	} coeff_fields_t;

	// one input word, read as sample/run length or as a coefficient
	typedef union packed
	{
		logic [WORD_W-1:0] raw;
		coeff_fields_t coeff;
	} msdap_word_u;

	typedef struct packed
	{
		msdap_word_u left;
		msdap_word_u right;
	} word_pair_t;

	// write strobes shared by both channels
	typedef struct packed
	{
		logic rj_we;
		logic coeff_we;
		logic sample_we;
	} load_cmd_t;

	typedef struct packed
	{
		logic clear;
		logic add;
		logic neg;
		logic shift;
	} acc_op_t;

endpackage
